// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mips
BUILD_DIR ?= build
SEED_LOG ?= sim.log
VFLAGS ?= --binary --timescale 1ns/1ps

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f sim.f --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BIN) > $(SEED_LOG) 2>&1
	@cat $(SEED_LOG)
	@if grep -q "TEST RESULT: FAIL" $(SEED_LOG); then \
		echo "Simulation reported a failure."; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(SEED_LOG); then \
		echo "Simulation ended without a pass line."; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)

// File: dv/tb_mips.sv
module tb_mips;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_isa_pkg::*;
	import mips_core_pkg::*;

	localparam int PROG_WORDS = 400;
	localparam int MEM_WORDS = 1024;
	localparam int DATA_BASE = 32'h800;
	localparam logic [XLEN-1:0] END_PC = (PROG_WORDS - 1) * 4;
	localparam int REQ_TIMEOUT = 64;
	localparam int ACK_TIMEOUT = 64;
	localparam logic [5:0] ALU_FUNCTS [6] = '{F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_SLT};
	localparam logic [5:0] IMM_OPS [6] = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	localparam logic [5:0] BAD_OPS [6] = '{6'h01, 6'h03, 6'h09, 6'h10, 6'h20, 6'h3f};

	logic clk;
	logic rst;
	wb_req_t wb;
	wb_rsp_t wb_rsp;

	// Instruction-set model state.
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] regs [32];
	logic [XLEN-1:0] model_mem [MEM_WORDS];

	mips_core dut (
		.clk    (clk),
		.rst    (rst),
		.wb     (wb),
		.wb_rsp (wb_rsp)
	);

	tb_wb_mem u_mem (
		.clk (clk),
		.req (wb),
		.rsp (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic show_mismatch(input string name, input wb_req_t exp, input wb_req_t act);
		$display("Fail %s: expected adr=%h we=%b sel=%h dat=%h, actual adr=%h we=%b sel=%h dat=%h",
			name, {exp.adr, 2'b00}, exp.we, exp.sel, exp.dat_w,
			{act.adr, 2'b00}, act.we, act.sel, act.dat_w);
		stop_run();
	endtask

	function automatic wb_req_t make_request(input logic we, input logic [XLEN-1:0] addr,
			input logic [XLEN-1:0] data);
		wb_req_t req;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = 4'hf;
		req.adr = addr[XLEN-1:2];
		req.dat_w = data;
		return req;
	endfunction

	task automatic compare_idle(input wb_req_t req);
		if (req.cyc !== 1'b0 || req.stb !== 1'b0) begin
			$display("Fail reset: expected cyc=0 stb=0, actual cyc=%b stb=%b", req.cyc, req.stb);
			stop_run();
		end
	endtask

	task automatic compare_fetch(input wb_req_t req, input logic [XLEN-1:0] exp_pc);
		wb_req_t act;
		act = req;
		// Write data means nothing on a read.
		act.dat_w = '0;
		if (act !== make_request(1'b0, exp_pc, '0)) begin
			show_mismatch("fetch", make_request(1'b0, exp_pc, '0), act);
		end
	endtask

	task automatic compare_load(input wb_req_t req, input logic [XLEN-1:0] exp_addr);
		wb_req_t act;
		act = req;
		act.dat_w = '0;
		if (act !== make_request(1'b0, exp_addr, '0)) begin
			show_mismatch("load", make_request(1'b0, exp_addr, '0), act);
		end
	endtask

	task automatic compare_store(input wb_req_t req, input logic [XLEN-1:0] exp_addr,
			input logic [XLEN-1:0] exp_data);
		if (req !== make_request(1'b1, exp_addr, exp_data)) begin
			show_mismatch("store", make_request(1'b1, exp_addr, exp_data), req);
		end
	endtask

	task automatic wait_request(output wb_req_t req);
		int n;
		n = 0;
		@(negedge clk);
		while (!(wb.cyc && wb.stb)) begin
			if (n == REQ_TIMEOUT) begin
				$display("Timeout: the core stopped issuing bus cycles for %0d cycles.", n);
				stop_run();
			end
			n++;
			@(negedge clk);
		end
		req = wb;
	endtask

	// The request must not move until the slave acks it.
	task automatic finish_access(input wb_req_t req);
		int n;
		n = 0;
		@(negedge clk);
		while (wb.stb) begin
			if (wb !== req) begin
				show_mismatch("hold until ack", req, wb);
			end
			if (n == ACK_TIMEOUT) begin
				$display("Timeout: the bus cycle was never acknowledged.");
				stop_run();
			end
			n++;
			@(negedge clk);
		end
		if (wb.cyc) begin
			$display("Error: cyc stayed high after stb was dropped.");
			stop_run();
		end
	endtask

	function automatic logic [XLEN-1:0] fill_word(input int idx);
		return {idx[15:0] ^ 16'h3c5a, ~idx[15:0]};
	endfunction

	function automatic logic [XLEN-1:0] gen_word(input int idx);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		logic [15:0] daddr;
		int kind;
		int off;
		int target;
		rs = 5'($urandom_range(7, 0));
		rt = 5'($urandom_range(7, 0));
		rd = 5'($urandom_range(7, 0));
		imm = 16'($urandom);
		daddr = 16'(DATA_BASE + 4 * $urandom_range(15, 0));
		kind = $urandom_range(99, 0);
		off = $urandom_range(3, 0);
		target = idx + 1 + $urandom_range(4, 0);
		// Branches and jumps only go forward and never past the final loop.
		if (idx + 1 + off > PROG_WORDS - 1) begin
			off = PROG_WORDS - 2 - idx;
		end
		if (target > PROG_WORDS - 1) begin
			target = PROG_WORDS - 1;
		end
		if (idx == PROG_WORDS - 1) begin
			return {OP_J, 26'(idx)};
		end else if (kind < 30) begin
			return {OP_RTYPE, rs, rt, rd, 5'd0, ALU_FUNCTS[3'($urandom_range(5, 0))]};
		end else if (kind < 55) begin
			return {IMM_OPS[3'($urandom_range(5, 0))], rs, rt, imm};
		end else if (kind < 72) begin
			return {OP_SW, 5'd0, rt, daddr};
		end else if (kind < 82) begin
			return {OP_LW, 5'd0, rt, daddr};
		end else if (kind < 90) begin
			return {($urandom_range(1, 0) == 0) ? OP_BEQ : OP_BNE, rs, rt, 16'(off)};
		end else if (kind < 95) begin
			return {OP_J, 26'(target)};
		end else if (kind < 97) begin
			return {BAD_OPS[3'($urandom_range(5, 0))], rs, rt, imm};
		end else begin
			return {OP_RTYPE, rs, rt, rd, 5'd0, 6'($urandom_range(31, 0))};
		end
	endfunction

	task automatic execute_model(input instr_t w);
		wb_req_t req;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] simm;
		logic [XLEN-1:0] zimm;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] npc;
		a = regs[w.r.rs];
		b = regs[w.r.rt];
		simm = {{16{w.i.imm16[15]}}, w.i.imm16};
		zimm = {16'h0, w.i.imm16};
		addr = a + simm;
		npc = pc + 4;
		case (w.r.opcode)
			OP_RTYPE: begin
				case (w.r.funct)
					F_ADD: regs[w.r.rd] = a + b;
					F_SUB: regs[w.r.rd] = a - b;
					F_AND: regs[w.r.rd] = a & b;
					F_OR: regs[w.r.rd] = a | b;
					F_XOR: regs[w.r.rd] = a ^ b;
					F_SLT: regs[w.r.rd] = {31'd0, $signed(a) < $signed(b)};
					default: ;
				endcase
			end
			OP_ADDI: regs[w.i.rt] = a + simm;
			OP_SLTI: regs[w.i.rt] = {31'd0, $signed(a) < $signed(simm)};
			OP_ANDI: regs[w.i.rt] = a & zimm;
			OP_ORI: regs[w.i.rt] = a | zimm;
			OP_XORI: regs[w.i.rt] = a ^ zimm;
			OP_LUI: regs[w.i.rt] = {w.i.imm16, 16'h0};
			OP_LW: begin
				wait_request(req);
				compare_load(req, addr);
				finish_access(req);
				regs[w.i.rt] = model_mem[addr[11:2]];
			end
			OP_SW: begin
				wait_request(req);
				compare_store(req, addr, b);
				finish_access(req);
				model_mem[addr[11:2]] = b;
			end
			OP_BEQ: begin
				if (a == b) npc = npc + {simm[29:0], 2'b00};
			end
			OP_BNE: begin
				if (a != b) npc = npc + {simm[29:0], 2'b00};
			end
			OP_J: npc = {npc[31:28], w.j.target26, 2'b00};
			default: ;
		endcase
		regs[0] = '0;
		pc = npc;
	endtask

	initial begin
		wb_req_t req;
		logic end_seen;
		logic done;
		void'($urandom(32'h39450eb4));
		rst = 1'b1;
		pc = RESET_PC;
		end_seen = 1'b0;
		done = 1'b0;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = (i < PROG_WORDS) ? gen_word(i) : fill_word(i);
			u_mem.mem[i] = model_mem[i];
		end
		repeat (10) begin
			@(negedge clk);
			compare_idle(wb);
		end
		rst = 1'b0;
		// The run ends once the closing self-loop has been fetched twice.
		while (!done) begin
			wait_request(req);
			compare_fetch(req, pc);
			finish_access(req);
			if (pc == END_PC && end_seen) begin
				done = 1'b1;
			end else begin
				end_seen = (pc == END_PC);
				execute_model(model_mem[pc[11:2]]);
			end
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: dv/tb_wb_mem.sv
module tb_wb_mem (
	input  logic                   clk,
	input  mips_core_pkg::wb_req_t req,
	output mips_core_pkg::wb_rsp_t rsp
);
	timeunit 1ns;
	timeprecision 1ps;
	import mips_core_pkg::*;

	localparam int DEPTH = 1024;
	localparam int MAX_WAIT = 3;

	// Program and data words, indexed by word address.
	logic [XLEN-1:0] mem [DEPTH];
	int wait_left;

	initial begin
		rsp = '0;
		wait_left = 2;
	end

	// The slave answers on the falling edge, so ack and read data are settled
	// well before the core samples them.
	always @(negedge clk) begin
		if (req.cyc && req.stb && !rsp.ack) begin
			if (wait_left == 0) begin
				rsp.ack = 1'b1;
				rsp.dat_r = mem[req.adr[9:0]];
				if (req.we) begin
					mem[req.adr[9:0]] = req.dat_w;
				end
				wait_left = $urandom_range(MAX_WAIT, 0);
			end else begin
				wait_left = wait_left - 1;
			end
		end else begin
			// Ack lasts one cycle since the core drops stb right after it.
			rsp.ack = 1'b0;
		end
	end

endmodule

// File: sim.f
verilog/mips_isa_pkg.sv
verilog/mips_core_pkg.sv
verilog/mips_control.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_core.sv
dv/tb_wb_mem.sv
dv/tb_mips.sv

// File: verilog/mips_alu.sv
module mips_alu (
	input  mips_core_pkg::alu_op_e          op,
	input  logic [mips_core_pkg::XLEN-1:0]  a,
	input  logic [mips_core_pkg::XLEN-1:0]  b,
	output logic [mips_core_pkg::XLEN-1:0]  result,
	output logic                            zero
);
	import mips_core_pkg::*;

	localparam int HALF = XLEN / 2;

	logic lt;

	// Signed compare for SLT and SLTI.
	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {{(XLEN-1){1'b0}}, lt};
			// LUI moves the immediate into the upper half. Operand a is not used.
			ALU_LUI: result = {b[HALF-1:0], {HALF{1'b0}}};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: verilog/mips_control.sv
module mips_control (
	input  mips_isa_pkg::instr_t instr,
	output mips_core_pkg::ctrl_t ctrl
);
	import mips_isa_pkg::*;
	import mips_core_pkg::*;

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		case (instr.r.opcode)
			OP_RTYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst = 1'b1;
				case (instr.r.funct)
					F_ADD: ctrl.alu_op = ALU_ADD;
					F_SUB: ctrl.alu_op = ALU_SUB;
					F_AND: ctrl.alu_op = ALU_AND;
					F_OR: ctrl.alu_op = ALU_OR;
					F_XOR: ctrl.alu_op = ALU_XOR;
					F_SLT: ctrl.alu_op = ALU_SLT;
					// Unknown funct falls back to a no-op.
					default: ctrl = '0;
				endcase
			end
			OP_ADDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
			end
			OP_SLTI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu_op = ALU_SLT;
			end
			OP_ANDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.alu_op = ALU_AND;
			end
			OP_ORI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.alu_op = ALU_OR;
			end
			OP_XORI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.alu_op = ALU_XOR;
			end
			OP_LUI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu_op = ALU_LUI;
			end
			OP_LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread = 1'b1;
				ctrl.alusrc = 1'b1;
			end
			OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc = 1'b1;
			end
			// Branches compare by subtraction and test the zero flag.
			OP_BEQ: begin
				ctrl.isbranch = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			OP_BNE: begin
				ctrl.isbranch = 1'b1;
				ctrl.branch_ne = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			OP_J: begin
				ctrl.isjump = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: verilog/mips_core.sv
module mips_core (
	input  logic                    clk,
	input  logic                    rst,
	output mips_core_pkg::wb_req_t  wb,
	input  mips_core_pkg::wb_rsp_t  wb_rsp
);
	import mips_isa_pkg::*;
	import mips_core_pkg::*;

	typedef enum logic [1:0] {
		FETCH,
		EXEC,
		MEM,
		WB
	} state_e;

	state_e state;
	logic [XLEN-1:0] pc;
	instr_t ir;
	logic [XLEN-1:0] load_data;

	ctrl_t ctrl;
	logic [XLEN-1:0] rs_data;
	logic [XLEN-1:0] rt_data;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	logic alu_zero;

	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] branch_target;
	logic [XLEN-1:0] jump_target;
	logic [XLEN-1:0] pc_next;
	logic take_branch;

	logic rf_we;
	logic [4:0] wr_addr;
	logic [XLEN-1:0] wr_data;
	logic bus_done;

	// Builds a single-word request; sel is always all ones.
	function automatic wb_req_t bus_req(input logic we, input logic [XLEN-1:0] addr,
			input logic [XLEN-1:0] data);
		wb_req_t req;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = '1;
		req.adr = addr[XLEN-1:2];
		req.dat_w = data;
		return req;
	endfunction

	mips_control u_control (
		.instr (ir),
		.ctrl  (ctrl)
	);

	mips_regfile u_regfile (
		.clk     (clk),
		.rst     (rst),
		.rs_addr (ir.r.rs),
		.rt_addr (ir.r.rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (rf_we),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	assign imm_ext = ctrl.zero_ext ? {{(XLEN-16){1'b0}}, ir.i.imm16}
		: {{(XLEN-16){ir.i.imm16[15]}}, ir.i.imm16};
	assign alu_b = ctrl.alusrc ? imm_ext : rt_data;

	mips_alu u_alu (
		.op     (ctrl.alu_op),
		.a      (rs_data),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// pc still holds the address of the instruction being executed.
	assign pc_plus4 = pc + 4;
	assign branch_target = pc_plus4 + {imm_ext[XLEN-3:0], 2'b00};
	assign jump_target = {pc_plus4[XLEN-1:28], ir.j.target26, 2'b00};
	assign take_branch = ctrl.isbranch & (alu_zero ^ ctrl.branch_ne);

	always_comb begin
		if (ctrl.isjump) begin
			pc_next = jump_target;
		end else if (take_branch) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	// ALU results retire in EXEC and load data one cycle after the ack.
	assign rf_we = ctrl.regwrite & (((state == EXEC) & ~ctrl.memread) | (state == WB));
	assign wr_addr = ctrl.regdst ? ir.r.rd : ir.i.rt;
	assign wr_data = ctrl.memtoreg ? load_data : alu_result;

	assign bus_done = wb.stb & wb_rsp.ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FETCH;
			pc <= RESET_PC;
			wb <= '0;
		end else begin
			case (state)
				FETCH: begin
					if (!wb.cyc) begin
						wb <= bus_req(1'b0, pc, '0);
					end else if (bus_done) begin
						wb.cyc <= 1'b0;
						wb.stb <= 1'b0;
						state <= EXEC;
					end
				end
				EXEC: begin
					pc <= pc_next;
					if (ctrl.memread || ctrl.memwrite) begin
						wb <= bus_req(ctrl.memwrite, alu_result, rt_data);
						state <= MEM;
					end else begin
						// Next fetch goes out straight away.
						wb <= bus_req(1'b0, pc_next, '0);
						state <= FETCH;
					end
				end
				MEM: begin
					if (bus_done) begin
						wb.cyc <= 1'b0;
						wb.stb <= 1'b0;
						wb.we <= 1'b0;
						state <= wb.we ? FETCH : WB;
					end
				end
				WB: begin
					wb <= bus_req(1'b0, pc, '0);
					state <= FETCH;
				end
				default: begin
					state <= FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bus_done) begin
			if (state == FETCH) begin
				ir <= wb_rsp.dat_r;
			end else if (state == MEM && !wb.we) begin
				load_data <= wb_rsp.dat_r;
			end
		end
	end

endmodule

// File: verilog/mips_core_pkg.sv
package mips_core_pkg;

	localparam int XLEN = 32;
	localparam logic [XLEN-1:0] RESET_PC = '0;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	// Decoded control word for the instruction in the instruction register.
	// An all-zero word is a no-op.
	typedef struct packed {
		logic    regwrite;
		logic    memtoreg;
		logic    memread;
		logic    memwrite;
		logic    isbranch;
		logic    branch_ne;
		logic    regdst;
		logic    alusrc;
		logic    zero_ext;
		logic    isjump;
		alu_op_e alu_op;
	} ctrl_t;

	// Wishbone classic master request. adr is a word address.
	typedef struct packed {
		logic            cyc;
		logic            stb;
		logic            we;
		logic [3:0]      sel;
		logic [XLEN-3:0] adr;
		logic [XLEN-1:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic            ack;
		logic [XLEN-1:0] dat_r;
	} wb_rsp_t;

endpackage

// File: verilog/mips_isa_pkg.sv
package mips_isa_pkg;

	// Primary opcodes, bits 31:26 of the instruction word.
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// Function codes of the R-type instructions, bits 5:0.
	typedef enum logic [5:0] {
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_XOR = 6'h26,
		F_SLT = 6'h2a
	} funct_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target26;
	} j_fmt_t;

	// All three views share the opcode field in the top six bits.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_t;

endpackage

// File: verilog/mips_regfile.sv
module mips_regfile (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [4:0]                      rs_addr,
	input  logic [4:0]                      rt_addr,
	output logic [mips_core_pkg::XLEN-1:0]  rs_data,
	output logic [mips_core_pkg::XLEN-1:0]  rt_data,
	input  logic                            we,
	input  logic [4:0]                      wr_addr,
	input  logic [mips_core_pkg::XLEN-1:0]  wr_data
);
	import mips_core_pkg::*;

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Register zero is a constant.
	assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

endmodule
